// File: src/fe_defines.svh
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// address widths
`define FE_VADDR_WIDTH 16
`define FE_PADDR_WIDTH 20
`define FE_PAGE_OFFSET_WIDTH 8

// storage depths
`define FE_ITLB_ENTRIES 4
`define FE_FIFO_DEPTH 4

// stale work tag
`define FE_EPOCH_WIDTH 2

`define FE_RESET_PC 16'h0100

`endif

// File: src/fe_types_pkg.sv
`include "fe_defines.svh"

package fe_types_pkg;

   // virtual fetch pc
   typedef logic [`FE_VADDR_WIDTH-1:0] vaddr_t;

   // physical address a cache would read
   typedef logic [`FE_PADDR_WIDTH-1:0] paddr_t;

   // page numbers, address minus page offset
   typedef logic [`FE_VADDR_WIDTH-`FE_PAGE_OFFSET_WIDTH-1:0] vtag_t;
   typedef logic [`FE_PADDR_WIDTH-`FE_PAGE_OFFSET_WIDTH-1:0] ptag_t;

   typedef logic [`FE_PAGE_OFFSET_WIDTH-1:0] offset_t;

   // bumped by every back-end command
   typedef logic [`FE_EPOCH_WIDTH-1:0] epoch_t;

   // queue message kinds
   typedef enum logic
   {
      e_msg_fetch     = 1'b0,
      e_msg_itlb_miss = 1'b1
   } fe_msg_e;

endpackage

// File: src/fe_cmd_pkg.sv
package fe_cmd_pkg;

   // back-end command opcodes, 2'b11 unused
   typedef enum logic [1:0]
   {
      e_op_state_reset = 2'b00,
      e_op_pc_redirect = 2'b01,
      e_op_itlb_fill   = 2'b10
   } fe_opcode_e;

   // pc generator
   // e_run fetches, e_wait_fill idles after a miss until a command
   typedef enum logic
   {
      e_run       = 1'b0,
      e_wait_fill = 1'b1
   } pc_gen_state_e;

endpackage

// File: src/fe_pc_gen.sv
`include "fe_defines.svh"

module fe_pc_gen
   import fe_types_pkg::*;
   import fe_cmd_pkg::*;
(
   input  logic          clk_i
   , input  logic        rst_n_i

   , input  logic        cmd_v_i
   , output logic        cmd_ready_o
   , input  fe_opcode_e  cmd_opcode_i
   , input  vaddr_t      cmd_pc_i
   , input  ptag_t       cmd_ptag_i

   , output logic        req_v_o
   , input  logic        req_ready_i
   , output vaddr_t      req_pc_o
   , output epoch_t      req_epoch_o

   , output logic        fill_v_o
   , output vtag_t       fill_vtag_o
   , output ptag_t       fill_ptag_o
   , output logic        flush_v_o

   , input  logic        miss_taken_i
   , output epoch_t      cur_epoch_o
);

   pc_gen_state_e state_r;
   pc_gen_state_e state_n;
   vaddr_t        pc_r;
   epoch_t        epoch_r;
   logic          req_v_r;
   logic          cmd_load;
   logic          req_fire;

   // commands are never back-pressured
   assign cmd_ready_o = 1'b1;

   assign cmd_load = cmd_v_i && cmd_ready_o
                     && (cmd_opcode_i inside {e_op_state_reset, e_op_pc_redirect, e_op_itlb_fill});
   assign req_fire = req_v_o && req_ready_i;

   // itlb write side, taken on the command edge
   assign fill_v_o    = cmd_load && (cmd_opcode_i == e_op_itlb_fill);
   assign fill_vtag_o = cmd_pc_i[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH];
   assign fill_ptag_o = cmd_ptag_i;
   assign flush_v_o   = cmd_load && (cmd_opcode_i == e_op_state_reset);

   assign req_v_o     = req_v_r;
   assign req_pc_o    = pc_r;
   assign req_epoch_o = epoch_r;
   assign cur_epoch_o = epoch_r;

   // a command beats a miss in the same cycle
   always_comb
   begin
      state_n = state_r;
      if (cmd_load)
         state_n = e_run;
      else if (miss_taken_i)
         state_n = e_wait_fill;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= e_run;
         req_v_r <= 1'b0;
         pc_r    <= `FE_RESET_PC;
         epoch_r <= '0;
      end
      else
      begin
         state_r <= state_n;
         req_v_r <= (state_n == e_run);
         if (cmd_load)
         begin
            pc_r    <= cmd_pc_i;
            epoch_r <= epoch_r + 1'b1;
         end
         else if (req_fire)
            pc_r <= pc_r + vaddr_t'(4);
      end
   end

   a_no_req_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_r == e_wait_fill) |-> !req_v_o);

endmodule

// File: src/fe_itlb.sv
`include "fe_defines.svh"

module fe_itlb
   import fe_types_pkg::*;
(
   input  logic     clk_i
   , input  logic   rst_n_i

   , input  logic   req_v_i
   , output logic   req_ready_o
   , input  vaddr_t req_pc_i
   , input  epoch_t req_epoch_i

   , input  logic   fill_v_i
   , input  vtag_t  fill_vtag_i
   , input  ptag_t  fill_ptag_i
   , input  logic   flush_v_i

   , output logic   out_v_o
   , input  logic   out_ready_i
   , output vaddr_t out_pc_o
   , output paddr_t out_paddr_o
   , output logic   out_miss_o
   , output epoch_t out_epoch_o
);

   localparam int N     = `FE_ITLB_ENTRIES;
   localparam int IDX_W = $clog2(N);

   logic [N-1:0]     valid_r;
   vtag_t            vtag_r [N];
   ptag_t            ptag_r [N];
   logic [IDX_W-1:0] rr_r;

   vtag_t            req_vtag;
   offset_t          req_off;
   logic [N-1:0]     hit_vec;
   logic [N-1:0]     fill_match;
   ptag_t            hit_ptag;
   logic [IDX_W-1:0] fill_idx;
   logic             req_fire;

   assign req_vtag = req_pc_i[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH];
   assign req_off  = req_pc_i[`FE_PAGE_OFFSET_WIDTH-1:0];

   // output register holds while the buffer is full
   assign req_ready_o = !out_v_o || out_ready_i;
   assign req_fire    = req_v_i && req_ready_o;

   // cam compare for lookup and for fill replacement
   always_comb
   begin
      hit_ptag = '0;
      fill_idx = rr_r;
      for (int i = 0; i < N; i++)
      begin
         hit_vec[i]    = valid_r[i] && (vtag_r[i] == req_vtag);
         fill_match[i] = valid_r[i] && (vtag_r[i] == fill_vtag_i);
         if (hit_vec[i])
            hit_ptag = hit_ptag | ptag_r[i];
         if (fill_match[i])
            fill_idx = IDX_W'(i);
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         valid_r <= '0;
         rr_r    <= '0;
      end
      else if (flush_v_i)
      begin
         valid_r <= '0;
         rr_r    <= '0;
      end
      else if (fill_v_i)
      begin
         valid_r[fill_idx] <= 1'b1;
         // round robin only advances on a fresh page
         if (!(|fill_match))
            rr_r <= rr_r + 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
      begin
         vtag_r[fill_idx] <= fill_vtag_i;
         ptag_r[fill_idx] <= fill_ptag_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         out_v_o <= 1'b0;
      else if (req_fire)
         out_v_o <= 1'b1;
      else if (out_ready_i)
         out_v_o <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (req_fire)
      begin
         out_pc_o    <= req_pc_i;
         out_paddr_o <= {hit_ptag, req_off};
         out_miss_o  <= !(|hit_vec);
         out_epoch_o <= req_epoch_i;
      end
   end

   a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_v_i |-> $onehot0(hit_vec));

endmodule

// File: src/fe_fetch_fifo.sv
`include "fe_defines.svh"

module fe_fetch_fifo
   import fe_types_pkg::*;
(
   input  logic     clk_i
   , input  logic   rst_n_i

   , input  logic   wr_v_i
   , output logic   wr_ready_o
   , input  vaddr_t wr_pc_i
   , input  paddr_t wr_paddr_i
   , input  logic   wr_miss_i
   , input  epoch_t wr_epoch_i

   , output logic   rd_v_o
   , input  logic   rd_ready_i
   , output vaddr_t rd_pc_o
   , output paddr_t rd_paddr_o
   , output logic   rd_miss_o
   , output epoch_t rd_epoch_o
);

   localparam int DEPTH = `FE_FIFO_DEPTH;
   localparam int IDX_W = $clog2(DEPTH);

   vaddr_t           pc_mem    [DEPTH];
   paddr_t           paddr_mem [DEPTH];
   epoch_t           epoch_mem [DEPTH];
   logic [DEPTH-1:0] miss_mem;

   // extra msb tells full from empty
   logic [IDX_W:0]   wr_ptr_r;
   logic [IDX_W:0]   rd_ptr_r;
   logic [IDX_W-1:0] wr_idx;
   logic [IDX_W-1:0] rd_idx;
   logic             full;
   logic             empty;

   assign wr_idx = wr_ptr_r[IDX_W-1:0];
   assign rd_idx = rd_ptr_r[IDX_W-1:0];
   assign full   = (wr_ptr_r[IDX_W] != rd_ptr_r[IDX_W]) && (wr_idx == rd_idx);
   assign empty  = (wr_ptr_r == rd_ptr_r);

   assign wr_ready_o = !full;
   assign rd_v_o     = !empty;
   assign rd_pc_o    = pc_mem[rd_idx];
   assign rd_paddr_o = paddr_mem[rd_idx];
   assign rd_miss_o  = miss_mem[rd_idx];
   assign rd_epoch_o = epoch_mem[rd_idx];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
      end
      else
      begin
         if (wr_v_i && wr_ready_o)
            wr_ptr_r <= wr_ptr_r + 1'b1;
         if (rd_v_o && rd_ready_i)
            rd_ptr_r <= rd_ptr_r + 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_v_i && wr_ready_o)
      begin
         pc_mem[wr_idx]    <= wr_pc_i;
         paddr_mem[wr_idx] <= wr_paddr_i;
         miss_mem[wr_idx]  <= wr_miss_i;
         epoch_mem[wr_idx] <= wr_epoch_i;
      end
   end

   a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      full |=> (wr_ptr_r == $past(wr_ptr_r)));

   a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      empty |=> (rd_ptr_r == $past(rd_ptr_r)));

endmodule

// File: src/fe_queue_out.sv
module fe_queue_out
   import fe_types_pkg::*;
(
   input  logic      clk_i
   , input  logic    rst_n_i

   , input  logic    head_v_i
   , output logic    head_ready_o
   , input  vaddr_t  head_pc_i
   , input  paddr_t  head_paddr_i
   , input  logic    head_miss_i
   , input  epoch_t  head_epoch_i

   , input  epoch_t  cur_epoch_i
   , output logic    miss_taken_o

   , output logic    fe_queue_v_o
   , input  logic    fe_queue_ready_i
   , output fe_msg_e fe_queue_type_o
   , output vaddr_t  fe_queue_pc_o
   , output paddr_t  fe_queue_paddr_o
);

   logic   drop_r;
   epoch_t epoch_q;
   logic   drop;

   // stale or post-miss entries leave without a message
   assign drop = (head_epoch_i != cur_epoch_i) || drop_r;

   assign fe_queue_v_o     = head_v_i && !drop;
   assign head_ready_o     = drop || fe_queue_ready_i;
   assign fe_queue_type_o  = head_miss_i ? e_msg_itlb_miss : e_msg_fetch;
   assign fe_queue_pc_o    = head_pc_i;
   assign fe_queue_paddr_o = head_paddr_i;

   assign miss_taken_o = fe_queue_v_o && fe_queue_ready_i && head_miss_i;

   // set wins over the epoch change clear
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         drop_r  <= 1'b0;
         epoch_q <= '0;
      end
      else
      begin
         epoch_q <= cur_epoch_i;
         if (miss_taken_o)
            drop_r <= 1'b1;
         else if (cur_epoch_i != epoch_q)
            drop_r <= 1'b0;
      end
   end

endmodule

// File: src/fe_top.sv
module fe_top
   import fe_types_pkg::*;
   import fe_cmd_pkg::*;
(
   input  logic         clk_i
   , input  logic       rst_n_i

   , input  logic       fe_cmd_v_i
   , output logic       fe_cmd_ready_o
   , input  fe_opcode_e fe_cmd_opcode_i
   , input  vaddr_t     fe_cmd_pc_i
   , input  ptag_t      fe_cmd_ptag_i

   , output logic       fe_queue_v_o
   , input  logic       fe_queue_ready_i
   , output fe_msg_e    fe_queue_type_o
   , output vaddr_t     fe_queue_pc_o
   , output paddr_t     fe_queue_paddr_o
);

   // pc_gen to itlb
   logic   req_v;
   logic   req_ready;
   vaddr_t req_pc;
   epoch_t req_epoch;
   logic   fill_v;
   vtag_t  fill_vtag;
   ptag_t  fill_ptag;
   logic   flush_v;

   // itlb to fifo
   logic   itlb_v;
   logic   itlb_ready;
   vaddr_t itlb_pc;
   paddr_t itlb_paddr;
   logic   itlb_miss;
   epoch_t itlb_epoch;

   // fifo head
   logic   head_v;
   logic   head_ready;
   vaddr_t head_pc;
   paddr_t head_paddr;
   logic   head_miss;
   epoch_t head_epoch;

   logic   miss_taken;
   epoch_t cur_epoch;

   fe_pc_gen pc_gen_i
   (
      .clk_i         (clk_i)
      , .rst_n_i     (rst_n_i)
      , .cmd_v_i     (fe_cmd_v_i)
      , .cmd_ready_o (fe_cmd_ready_o)
      , .cmd_opcode_i(fe_cmd_opcode_i)
      , .cmd_pc_i    (fe_cmd_pc_i)
      , .cmd_ptag_i  (fe_cmd_ptag_i)
      , .req_v_o     (req_v)
      , .req_ready_i (req_ready)
      , .req_pc_o    (req_pc)
      , .req_epoch_o (req_epoch)
      , .fill_v_o    (fill_v)
      , .fill_vtag_o (fill_vtag)
      , .fill_ptag_o (fill_ptag)
      , .flush_v_o   (flush_v)
      , .miss_taken_i(miss_taken)
      , .cur_epoch_o (cur_epoch)
   );

   fe_itlb itlb_i
   (
      .clk_i        (clk_i)
      , .rst_n_i    (rst_n_i)
      , .req_v_i    (req_v)
      , .req_ready_o(req_ready)
      , .req_pc_i   (req_pc)
      , .req_epoch_i(req_epoch)
      , .fill_v_i   (fill_v)
      , .fill_vtag_i(fill_vtag)
      , .fill_ptag_i(fill_ptag)
      , .flush_v_i  (flush_v)
      , .out_v_o    (itlb_v)
      , .out_ready_i(itlb_ready)
      , .out_pc_o   (itlb_pc)
      , .out_paddr_o(itlb_paddr)
      , .out_miss_o (itlb_miss)
      , .out_epoch_o(itlb_epoch)
   );

   fe_fetch_fifo fifo_i
   (
      .clk_i       (clk_i)
      , .rst_n_i   (rst_n_i)
      , .wr_v_i    (itlb_v)
      , .wr_ready_o(itlb_ready)
      , .wr_pc_i   (itlb_pc)
      , .wr_paddr_i(itlb_paddr)
      , .wr_miss_i (itlb_miss)
      , .wr_epoch_i(itlb_epoch)
      , .rd_v_o    (head_v)
      , .rd_ready_i(head_ready)
      , .rd_pc_o   (head_pc)
      , .rd_paddr_o(head_paddr)
      , .rd_miss_o (head_miss)
      , .rd_epoch_o(head_epoch)
   );

   fe_queue_out queue_out_i
   (
      .clk_i             (clk_i)
      , .rst_n_i         (rst_n_i)
      , .head_v_i        (head_v)
      , .head_ready_o    (head_ready)
      , .head_pc_i       (head_pc)
      , .head_paddr_i    (head_paddr)
      , .head_miss_i     (head_miss)
      , .head_epoch_i    (head_epoch)
      , .cur_epoch_i     (cur_epoch)
      , .miss_taken_o    (miss_taken)
      , .fe_queue_v_o    (fe_queue_v_o)
      , .fe_queue_ready_i(fe_queue_ready_i)
      , .fe_queue_type_o (fe_queue_type_o)
      , .fe_queue_pc_o   (fe_queue_pc_o)
      , .fe_queue_paddr_o(fe_queue_paddr_o)
   );

endmodule

// File: bench/fe_tb.sv
`include "fe_defines.svh"

module fe_tb
   import fe_types_pkg::*;
   import fe_cmd_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // cycle budgets of tests 1 to 6
   localparam int WATCHDOG_CYCLES = 300 + 600 + 500 + 1200 + 900 + 500;
   localparam int PAGES = 1 << (`FE_VADDR_WIDTH - `FE_PAGE_OFFSET_WIDTH);

   logic       clk_i = 1'b0;
   logic       rst_n_i;
   logic       fe_cmd_v_i;
   logic       fe_cmd_ready_o;
   fe_opcode_e fe_cmd_opcode_i;
   vaddr_t     fe_cmd_pc_i;
   ptag_t      fe_cmd_ptag_i;
   logic       fe_queue_v_o;
   logic       fe_queue_ready_i;
   fe_msg_e    fe_queue_type_o;
   vaddr_t     fe_queue_pc_o;
   paddr_t     fe_queue_paddr_o;

   logic [15:0] lfsr = 16'd15;
   int          errors = 0;
   int          err_mark = 0;
   int          pass_count = 0;
   int          fail_count = 0;

   // reference model state
   logic [PAGES-1:0] page_v;
   ptag_t            page_ptag [PAGES];
   vaddr_t           exp_pc;
   logic             waiting;
   int               msg_count;
   int               miss_count;

   vtag_t   exp_vtag;
   logic    exp_hit;
   fe_msg_e exp_type;
   paddr_t  exp_paddr;
   logic    q_fire;
   logic    cmd_fire;

   fe_top dut_i
   (
      .clk_i             (clk_i)
      , .rst_n_i         (rst_n_i)
      , .fe_cmd_v_i      (fe_cmd_v_i)
      , .fe_cmd_ready_o  (fe_cmd_ready_o)
      , .fe_cmd_opcode_i (fe_cmd_opcode_i)
      , .fe_cmd_pc_i     (fe_cmd_pc_i)
      , .fe_cmd_ptag_i   (fe_cmd_ptag_i)
      , .fe_queue_v_o    (fe_queue_v_o)
      , .fe_queue_ready_i(fe_queue_ready_i)
      , .fe_queue_type_o (fe_queue_type_o)
      , .fe_queue_pc_o   (fe_queue_pc_o)
      , .fe_queue_paddr_o(fe_queue_paddr_o)
   );

   always #4 clk_i = ~clk_i;

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
   endtask

   always @(posedge clk_i)
   begin
      #1;
      lfsr = lfsr_step(lfsr);
      fe_queue_ready_i = lfsr[0];
   end

   assign q_fire    = fe_queue_v_o && fe_queue_ready_i;
   assign cmd_fire  = fe_cmd_v_i && fe_cmd_ready_o;
   assign exp_vtag  = exp_pc[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH];
   assign exp_hit   = page_v[exp_vtag];
   assign exp_type  = exp_hit ? e_msg_fetch : e_msg_itlb_miss;
   assign exp_paddr = {page_ptag[exp_vtag], exp_pc[`FE_PAGE_OFFSET_WIDTH-1:0]};

   // a message is checked before a command on the same edge applies
   always @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         page_v     <= '0;
         exp_pc     <= `FE_RESET_PC;
         waiting    <= 1'b0;
         msg_count  <= 0;
         miss_count <= 0;
      end
      else
      begin
         if (q_fire)
         begin
            msg_count <= msg_count + 1;
            if (exp_hit)
               exp_pc <= exp_pc + vaddr_t'(4);
            else
            begin
               miss_count <= miss_count + 1;
               waiting    <= 1'b1;
            end
         end
         if (cmd_fire)
         begin
            exp_pc  <= fe_cmd_pc_i;
            waiting <= 1'b0;
            if (fe_cmd_opcode_i == e_op_itlb_fill)
            begin
               page_v[fe_cmd_pc_i[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH]]    <= 1'b1;
               page_ptag[fe_cmd_pc_i[`FE_VADDR_WIDTH-1:`FE_PAGE_OFFSET_WIDTH]] <= fe_cmd_ptag_i;
            end
            else if (fe_cmd_opcode_i == e_op_state_reset)
               page_v <= '0;
         end
      end
   end

   a_cmd_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fe_cmd_ready_o)
      else report_value("fe_cmd_ready_o", $sampled(fe_cmd_ready_o), 1);

   a_msg_type: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      q_fire |-> (fe_queue_type_o == exp_type))
      else report_value("fe_queue_type_o", $sampled(fe_queue_type_o), $sampled(exp_type));

   a_msg_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      q_fire |-> (fe_queue_pc_o == exp_pc))
      else report_value("fe_queue_pc_o", $sampled(fe_queue_pc_o), $sampled(exp_pc));

   a_msg_paddr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (q_fire && exp_hit) |-> (fe_queue_paddr_o == exp_paddr))
      else report_value("fe_queue_paddr_o", $sampled(fe_queue_paddr_o), $sampled(exp_paddr));

   a_quiet_after_miss: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      waiting |-> !fe_queue_v_o)
      else
      begin
         $display("message offered at %0t after a miss with no command since", $time);
         errors++;
      end

   // the command edge may kill a stalled message
   a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (fe_queue_v_o && !fe_queue_ready_i && !cmd_fire) |=>
      (fe_queue_v_o && $stable(fe_queue_type_o) && $stable(fe_queue_pc_o)
       && $stable(fe_queue_paddr_o)))
      else
      begin
         $display("queue message dropped or changed while stalled at %0t", $time);
         errors++;
      end

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic send_cmd(input fe_opcode_e op, input vaddr_t pc, input ptag_t ptag);
      logic seen_ready;
      fe_cmd_v_i      = 1'b1;
      fe_cmd_opcode_i = op;
      fe_cmd_pc_i     = pc;
      fe_cmd_ptag_i   = ptag;
      do
      begin
         seen_ready = fe_cmd_ready_o;
         next_cycle();
      end
      while (!seen_ready);
      fe_cmd_v_i = 1'b0;
   endtask

   task automatic wait_msgs(input int n);
      int target;
      target = msg_count + n;
      while (msg_count < target)
         next_cycle();
   endtask

   task automatic wait_miss();
      int target;
      target = miss_count + 1;
      while (miss_count < target)
         next_cycle();
   endtask

   task automatic end_test(input int num, input string name);
      if (errors == err_mark)
      begin
         pass_count++;
         $display("test %0d %s: pass", num, name);
      end
      else
      begin
         fail_count++;
         $display("test %0d %s: fail", num, name);
      end
      err_mark = errors;
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
      $display("tests failed");
      $finish;
   end

   initial
   begin
      rst_n_i          = 1'b0;
      fe_cmd_v_i       = 1'b0;
      fe_cmd_opcode_i  = e_op_state_reset;
      fe_cmd_pc_i      = '0;
      fe_cmd_ptag_i    = '0;
      fe_queue_ready_i = 1'b0;
      repeat (16) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      wait_miss();
      idle_cycles(40);
      end_test(1, "miss after reset");

      send_cmd(e_op_itlb_fill, `FE_RESET_PC, 12'h3a5);
      wait_msgs(20);
      end_test(2, "fill then fetch");

      send_cmd(e_op_pc_redirect, 16'h0180, '0);
      wait_msgs(10);
      end_test(3, "redirect");

      // long run over page 1 after its entry is refilled
      send_cmd(e_op_itlb_fill, 16'h0104, 12'h5a0);
      wait_msgs(40);
      end_test(4, "random ready");

      // eight fetches to the page end before page 2 misses
      send_cmd(e_op_pc_redirect, 16'h01e0, '0);
      wait_miss();
      idle_cycles(40);
      send_cmd(e_op_itlb_fill, 16'h0200, 12'h0c4);
      wait_msgs(8);
      end_test(5, "page crossing");

      send_cmd(e_op_state_reset, `FE_RESET_PC, '0);
      wait_miss();
      idle_cycles(30);
      end_test(6, "state reset");

      $display("%0d passed, %0d failed, %0d check errors", pass_count, fail_count, errors);
      if (fail_count == 0 && errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: sim.f
+incdir+src
src/fe_types_pkg.sv
src/fe_cmd_pkg.sv
src/fe_pc_gen.sv
src/fe_itlb.sv
src/fe_fetch_fifo.sv
src/fe_queue_out.sv
src/fe_top.sv
bench/fe_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/Vfe_tb
	./obj_dir/Vfe_tb | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

obj_dir/Vfe_tb: sim.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module fe_tb -f sim.f

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module fe_tb -f sim.f

clean:
	rm -rf obj_dir $(LOG)
